// File: source/cpu_types_pkg.sv
package cpu_types_pkg;

	// integer opcodes, reduced to the ones the pairing rules look at
	typedef enum logic [5:0] {
		OP_NOP = 6'd0,
		OP_SSNOP,
		OP_ADD,
		OP_MUL,
		OP_MOVZ,
		OP_MOVN,
		OP_LB,
		OP_LW,
		OP_LWC1,
		OP_SB,
		OP_SW,
		OP_SWC1,
		OP_BEQ,
		OP_BNE,
		OP_J,
		OP_JAL,
		OP_JR,
		OP_BC1,
		OP_CFC1,
		OP_CTC1,
		OP_MFC0,
		OP_MTC0,
		OP_ERET,
		OP_TLBWI,
		OP_CACHE
	} oper_t;

	typedef enum logic [2:0] {
		FPU_OP_NOP = 3'd0,
		FPU_OP_ADD,
		FPU_OP_MOV,
		FPU_OP_CMOV
	} fpu_oper_t;

	// one decoded instruction as it sits in the issue queue
	typedef struct packed {
		oper_t       op;
		fpu_oper_t   fpu_op;
		logic [4:0]  reg_addr1;
		logic [4:0]  reg_addr2;
		logic [4:0]  reg_waddr;
		logic        reg_we;
		logic [4:0]  fpu_raddr1;
		logic [4:0]  fpu_raddr2;
		logic [4:0]  fpu_waddr;
		logic        fpu_we;
		logic        delayslot;
		logic [31:0] pc;
	} inst_entry_t;

	typedef struct packed {
		logic        valid_a;
		inst_entry_t entry_a;
		logic        valid_b;
		inst_entry_t entry_b;
	} issue_t;

endpackage

// File: source/bus_pkg.sv
package bus_pkg;

	typedef struct packed {
		logic        psel;
		logic        penable;
		logic        pwrite;
		logic [7:0]  paddr;
		logic [31:0] pwdata;
	} apb_req_t;

	typedef struct packed {
		logic [31:0] prdata;
		logic        pready;
		logic        pslverr;
	} apb_rsp_t;

	// register map of the issue port
	typedef enum logic [7:0] {
		REG_INST_LO  = 8'h00,
		REG_INST_HI  = 8'h04,
		// write pushes the staged entry with this pc
		REG_INST_PC  = 8'h08,
		REG_LEVEL    = 8'h0c,
		REG_DUAL_CNT = 8'h10
	} reg_offset_t;

endpackage

// File: source/superscalar_ctrl.sv
`timescale 1ns/1ps

module superscalar_ctrl (
	input  cpu_types_pkg::inst_entry_t data_a,
	input  cpu_types_pkg::inst_entry_t data_b,
	output logic                       inst2_taken
);

	function automatic logic is_read_memory(input cpu_types_pkg::oper_t op);
		return op == cpu_types_pkg::OP_LB || op == cpu_types_pkg::OP_LW ||
			op == cpu_types_pkg::OP_LWC1;
	endfunction

	function automatic logic is_write_memory(input cpu_types_pkg::oper_t op);
		return op == cpu_types_pkg::OP_SB || op == cpu_types_pkg::OP_SW ||
			op == cpu_types_pkg::OP_SWC1;
	endfunction

	function automatic logic is_branch(input cpu_types_pkg::oper_t op);
		return op == cpu_types_pkg::OP_BEQ || op == cpu_types_pkg::OP_BNE ||
			op == cpu_types_pkg::OP_J || op == cpu_types_pkg::OP_JAL ||
			op == cpu_types_pkg::OP_JR || op == cpu_types_pkg::OP_BC1;
	endfunction

	function automatic logic is_cond_move(input cpu_types_pkg::oper_t op,
			input cpu_types_pkg::fpu_oper_t fop);
		return op == cpu_types_pkg::OP_MOVZ || op == cpu_types_pkg::OP_MOVN ||
			fop == cpu_types_pkg::FPU_OP_MOV;
	endfunction

	// ops that must run alone on pipe a because they touch fpu control state
	function automatic logic is_fpu_exclusive(input cpu_types_pkg::oper_t op,
			input cpu_types_pkg::fpu_oper_t fop);
		return op == cpu_types_pkg::OP_CFC1 || op == cpu_types_pkg::OP_CTC1 ||
			op == cpu_types_pkg::OP_BC1 || fop == cpu_types_pkg::FPU_OP_CMOV;
	endfunction

	function automatic logic is_privileged(input cpu_types_pkg::oper_t op);
		return op == cpu_types_pkg::OP_CACHE || op == cpu_types_pkg::OP_ERET ||
			op == cpu_types_pkg::OP_MFC0 || op == cpu_types_pkg::OP_MTC0 ||
			op == cpu_types_pkg::OP_TLBWI;
	endfunction

	logic read_mem_a, read_mem_b;
	logic mem_a, mem_b;
	logic branch_a, branch_b;
	logic cond_move_b;
	logic fpu_excl_a, fpu_excl_b;
	logic fpu_b;
	logic priv_a, priv_b;
	logic reg_dep, fpu_dep;

	assign read_mem_a  = is_read_memory(data_a.op);
	assign read_mem_b  = is_read_memory(data_b.op);
	assign mem_a       = read_mem_a | is_write_memory(data_a.op);
	assign mem_b       = read_mem_b | is_write_memory(data_b.op);
	assign branch_a    = is_branch(data_a.op);
	assign branch_b    = is_branch(data_b.op);
	assign cond_move_b = is_cond_move(data_b.op, data_b.fpu_op);
	assign fpu_excl_a  = is_fpu_exclusive(data_a.op, data_a.fpu_op);
	assign fpu_excl_b  = is_fpu_exclusive(data_b.op, data_b.fpu_op);
	assign fpu_b       = data_b.fpu_op != cpu_types_pkg::FPU_OP_NOP;
	assign priv_a      = is_privileged(data_a.op);
	assign priv_b      = is_privileged(data_b.op);

	// writes to r0 are discarded, so they never create a dependence
	assign reg_dep = data_a.reg_we && data_a.reg_waddr != 5'd0 &&
		(data_a.reg_waddr == data_b.reg_addr1 || data_a.reg_waddr == data_b.reg_addr2);

	assign fpu_dep = data_a.fpu_we && fpu_b &&
		(data_a.fpu_waddr == data_b.fpu_raddr1 || data_a.fpu_waddr == data_b.fpu_raddr2);

	// first matching rule wins
	always_comb begin
		if (data_a.op == cpu_types_pkg::OP_SSNOP || data_b.op == cpu_types_pkg::OP_SSNOP) begin
			inst2_taken = 1'b0;
		end else if (fpu_dep) begin
			inst2_taken = 1'b0;
		end else if (fpu_excl_a || fpu_excl_b) begin
			inst2_taken = 1'b0;
		end else if (cond_move_b && reg_dep) begin
			// condition is needed in ID but produced in EX
			inst2_taken = 1'b0;
		end else if (branch_b) begin
			inst2_taken = 1'b0;
		end else if (branch_a) begin
			// delay slot has to follow on pipe a
			inst2_taken = 1'b0;
		end else if (data_a.delayslot) begin
			inst2_taken = 1'b0;
		end else if (mem_a && mem_b) begin
			// single memory port
			inst2_taken = 1'b0;
		end else if (read_mem_a && reg_dep) begin
			inst2_taken = 1'b0;
		end else if (priv_a || priv_b) begin
			// cp0 access only from pipe a
			inst2_taken = 1'b0;
		end else if (data_a.op == cpu_types_pkg::OP_MUL && reg_dep) begin
			// mul result is two cycles late
			inst2_taken = 1'b0;
		end else if (data_b.pc[11:0] == 12'h000) begin
			// b may sit in a different TLB page
			inst2_taken = 1'b0;
		end else begin
			inst2_taken = 1'b1;
		end
	end

endmodule

// File: source/inst_queue.sv
`timescale 1ns/1ps

module inst_queue #(
	parameter int QUEUE_DEPTH = 8
) (
	input  logic                                clk,
	input  logic                                arst_n,
	input  logic                                push,
	input  cpu_types_pkg::inst_entry_t          push_entry,
	input  logic                                ena,
	input  logic                                inst2_taken,
	output cpu_types_pkg::inst_entry_t          head_a,
	output cpu_types_pkg::inst_entry_t          head_b,
	output logic [$clog2(QUEUE_DEPTH+1)-1:0]    level,
	output logic                                full,
	output logic                                dual_issue,
	output cpu_types_pkg::issue_t               issue
);

	localparam int PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
	localparam int LVL_W = $clog2(QUEUE_DEPTH + 1);

	cpu_types_pkg::inst_entry_t mem [QUEUE_DEPTH];
	cpu_types_pkg::inst_entry_t entry_a_q, entry_b_q;

	logic [PTR_W-1:0] wr_ptr, rd_ptr;
	logic [LVL_W-1:0] count_q, pop_cnt;
	logic             pop_one, pop_two;
	logic             valid_a_q, valid_b_q;

	// pointer advance with wrap, depth need not be a power of two
	function automatic logic [PTR_W-1:0] ptr_add(input logic [PTR_W-1:0] ptr,
			input int unsigned n);
		int unsigned sum;
		sum = ptr + n;
		if (sum >= QUEUE_DEPTH)
			sum = sum - QUEUE_DEPTH;
		return PTR_W'(sum);
	endfunction

	assign head_a = mem[rd_ptr];
	assign head_b = mem[ptr_add(rd_ptr, 1)];

	assign pop_one    = ena && count_q != '0;
	assign pop_two    = pop_one && count_q > LVL_W'(1) && inst2_taken;
	assign pop_cnt    = pop_two ? LVL_W'(2) : LVL_W'(pop_one);
	assign dual_issue = pop_two;

	assign level = count_q;
	assign full  = count_q == LVL_W'(QUEUE_DEPTH);

	always_ff @(posedge clk) begin
		if (push)
			mem[wr_ptr] <= push_entry;
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			wr_ptr    <= '0;
			rd_ptr    <= '0;
			count_q   <= '0;
			valid_a_q <= 1'b0;
			valid_b_q <= 1'b0;
		end else begin
			if (push)
				wr_ptr <= ptr_add(wr_ptr, 1);
			rd_ptr    <= ptr_add(rd_ptr, pop_cnt);
			count_q   <= count_q + LVL_W'(push) - pop_cnt;
			valid_a_q <= pop_one;
			valid_b_q <= pop_two;
		end
	end

	// issue payload only loads on a pop
	always_ff @(posedge clk) begin
		if (pop_one)
			entry_a_q <= head_a;
		if (pop_two)
			entry_b_q <= head_b;
	end

	assign issue = '{valid_a: valid_a_q, entry_a: entry_a_q,
		valid_b: valid_b_q, entry_b: entry_b_q};

	assert property (@(posedge clk) disable iff (!arst_n) count_q <= LVL_W'(QUEUE_DEPTH))
		else $error("queue level above depth");

	// the register port must check full before pushing
	assert property (@(posedge clk) disable iff (!arst_n) push |-> !full)
		else $error("push into full queue");

endmodule

// File: source/apb_issue_regs.sv
`timescale 1ns/1ps

module apb_issue_regs (
	input  logic                       clk,
	input  logic                       arst_n,
	input  bus_pkg::apb_req_t          apb_req,
	output bus_pkg::apb_rsp_t          apb_rsp,
	input  logic [31:0]                level,
	input  logic                       full,
	input  logic                       dual_issue,
	output logic                       push,
	output cpu_types_pkg::inst_entry_t push_entry
);

	bus_pkg::reg_offset_t offset;

	logic        access, wr_access, rd_access;
	logic [25:0] lo_q;
	logic [15:0] hi_q;
	logic [31:0] dual_cnt_q;
	logic [31:0] rdata;
	logic        err;

	assign offset    = bus_pkg::reg_offset_t'(apb_req.paddr);
	assign access    = apb_req.psel && apb_req.penable;
	assign wr_access = access && apb_req.pwrite;
	assign rd_access = access && !apb_req.pwrite;

	// staged halves of the next entry
	always_ff @(posedge clk) begin
		if (wr_access && offset == bus_pkg::REG_INST_LO)
			lo_q <= apb_req.pwdata[25:0];
		if (wr_access && offset == bus_pkg::REG_INST_HI)
			hi_q <= apb_req.pwdata[15:0];
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			dual_cnt_q <= '0;
		else if (dual_issue)
			dual_cnt_q <= dual_cnt_q + 32'd1;
	end

	assign push = wr_access && offset == bus_pkg::REG_INST_PC && !full;

	assign push_entry.op         = cpu_types_pkg::oper_t'(lo_q[5:0]);
	assign push_entry.fpu_op     = cpu_types_pkg::fpu_oper_t'(lo_q[8:6]);
	assign push_entry.reg_addr1  = lo_q[13:9];
	assign push_entry.reg_addr2  = lo_q[18:14];
	assign push_entry.reg_waddr  = lo_q[23:19];
	assign push_entry.reg_we     = lo_q[24];
	assign push_entry.delayslot  = lo_q[25];
	assign push_entry.fpu_raddr1 = hi_q[4:0];
	assign push_entry.fpu_raddr2 = hi_q[9:5];
	assign push_entry.fpu_waddr  = hi_q[14:10];
	assign push_entry.fpu_we     = hi_q[15];
	assign push_entry.pc         = apb_req.pwdata;

	always_comb begin
		rdata = '0;
		err   = 1'b0;
		case (offset)
			bus_pkg::REG_INST_LO:  rdata = {6'd0, lo_q};
			bus_pkg::REG_INST_HI:  rdata = {16'd0, hi_q};
			// write only, reads back as zero
			bus_pkg::REG_INST_PC:  err = apb_req.pwrite && full;
			bus_pkg::REG_LEVEL: begin
				rdata = level;
				err   = apb_req.pwrite;
			end
			bus_pkg::REG_DUAL_CNT: begin
				rdata = dual_cnt_q;
				err   = apb_req.pwrite;
			end
			default:               err = 1'b1;
		endcase
	end

	assign apb_rsp.pready  = 1'b1;
	assign apb_rsp.pslverr = access && err;
	assign apb_rsp.prdata  = (rd_access && !err) ? rdata : 32'd0;

	assert property (@(posedge clk) disable iff (!arst_n) apb_req.penable |-> apb_req.psel)
		else $error("penable without psel");

endmodule

// File: source/dual_issue_top.sv
`timescale 1ns/1ps

module dual_issue_top #(
	parameter int QUEUE_DEPTH = 8
) (
	input  logic                  clk,
	input  logic                  arst_n,
	input  logic                  ena,
	input  bus_pkg::apb_req_t     apb_req,
	output bus_pkg::apb_rsp_t     apb_rsp,
	output cpu_types_pkg::issue_t issue
);

	localparam int LVL_W = $clog2(QUEUE_DEPTH + 1);

	cpu_types_pkg::inst_entry_t push_entry;
	cpu_types_pkg::inst_entry_t head_a, head_b;

	logic [LVL_W-1:0] level;
	logic             push;
	logic             full;
	logic             dual_issue;
	logic             inst2_taken;

	apb_issue_regs regs_i (
		.clk        (clk),
		.arst_n     (arst_n),
		.apb_req    (apb_req),
		.apb_rsp    (apb_rsp),
		.level      (32'(level)),
		.full       (full),
		.dual_issue (dual_issue),
		.push       (push),
		.push_entry (push_entry)
	);

	inst_queue #(
		.QUEUE_DEPTH (QUEUE_DEPTH)
	) queue_i (
		.clk         (clk),
		.arst_n      (arst_n),
		.push        (push),
		.push_entry  (push_entry),
		.ena         (ena),
		.inst2_taken (inst2_taken),
		.head_a      (head_a),
		.head_b      (head_b),
		.level       (level),
		.full        (full),
		.dual_issue  (dual_issue),
		.issue       (issue)
	);

	// pairing decision for the two oldest entries
	superscalar_ctrl ctrl_i (
		.data_a      (head_a),
		.data_b      (head_b),
		.inst2_taken (inst2_taken)
	);

endmodule

// File: sim/issue_model.svh
`ifndef ISSUE_MODEL_SVH
`define ISSUE_MODEL_SVH

// reference queue contents, oldest entry at index 0
cpu_types_pkg::inst_entry_t model_q[$];
cpu_types_pkg::inst_entry_t exp_entry_a;
cpu_types_pkg::inst_entry_t exp_entry_b;
logic exp_valid_a = 1'b0;
logic exp_valid_b = 1'b0;
int unsigned model_dual_cnt = 0;

function automatic logic load_op(input cpu_types_pkg::oper_t op);
	return op inside {cpu_types_pkg::OP_LB, cpu_types_pkg::OP_LW, cpu_types_pkg::OP_LWC1};
endfunction

function automatic logic store_op(input cpu_types_pkg::oper_t op);
	return op inside {cpu_types_pkg::OP_SB, cpu_types_pkg::OP_SW, cpu_types_pkg::OP_SWC1};
endfunction

function automatic logic jump_op(input cpu_types_pkg::oper_t op);
	return op inside {cpu_types_pkg::OP_BEQ, cpu_types_pkg::OP_BNE, cpu_types_pkg::OP_J,
		cpu_types_pkg::OP_JAL, cpu_types_pkg::OP_JR, cpu_types_pkg::OP_BC1};
endfunction

function automatic logic fpuctl_op(input cpu_types_pkg::inst_entry_t e);
	return e.op inside {cpu_types_pkg::OP_CFC1, cpu_types_pkg::OP_CTC1, cpu_types_pkg::OP_BC1}
		|| e.fpu_op == cpu_types_pkg::FPU_OP_CMOV;
endfunction

function automatic logic cp0_op(input cpu_types_pkg::oper_t op);
	return op inside {cpu_types_pkg::OP_CACHE, cpu_types_pkg::OP_ERET, cpu_types_pkg::OP_MFC0,
		cpu_types_pkg::OP_MTC0, cpu_types_pkg::OP_TLBWI};
endfunction

// pairing chain, the earliest rule that matches blocks pipe b
function automatic logic may_pair(input cpu_types_pkg::inst_entry_t a,
		input cpu_types_pkg::inst_entry_t b);
	logic int_dep;
	logic fp_dep;
	logic cmove_b;
	int_dep = a.reg_we && a.reg_waddr != 5'd0 &&
		(b.reg_addr1 == a.reg_waddr || b.reg_addr2 == a.reg_waddr);
	fp_dep = a.fpu_we && b.fpu_op != cpu_types_pkg::FPU_OP_NOP &&
		(b.fpu_raddr1 == a.fpu_waddr || b.fpu_raddr2 == a.fpu_waddr);
	cmove_b = b.op inside {cpu_types_pkg::OP_MOVZ, cpu_types_pkg::OP_MOVN} ||
		b.fpu_op == cpu_types_pkg::FPU_OP_MOV;
	if (a.op == cpu_types_pkg::OP_SSNOP || b.op == cpu_types_pkg::OP_SSNOP) return 1'b0;
	if (fp_dep || fpuctl_op(a) || fpuctl_op(b)) return 1'b0;
	if (cmove_b && int_dep) return 1'b0;
	if (jump_op(b.op) || jump_op(a.op) || a.delayslot) return 1'b0;
	if ((load_op(a.op) || store_op(a.op)) && (load_op(b.op) || store_op(b.op))) return 1'b0;
	if (load_op(a.op) && int_dep) return 1'b0;
	if (cp0_op(a.op) || cp0_op(b.op)) return 1'b0;
	if (a.op == cpu_types_pkg::OP_MUL && int_dep) return 1'b0;
	return b.pc[11:0] != 12'h000;
endfunction

// one rising edge: pops use the occupancy before the edge, then the push lands
function automatic void apply_edge(input logic ena_in, input logic push_in,
		input cpu_types_pkg::inst_entry_t entry_in);
	logic was_full;
	was_full = model_q.size() == QUEUE_DEPTH;
	exp_valid_a = 1'b0;
	exp_valid_b = 1'b0;
	if (ena_in && model_q.size() > 0) begin
		exp_valid_a = 1'b1;
		exp_entry_a = model_q.pop_front();
		if (model_q.size() > 0 && may_pair(exp_entry_a, model_q[0])) begin
			exp_valid_b = 1'b1;
			exp_entry_b = model_q.pop_front();
			model_dual_cnt++;
		end
	end
	if (push_in && !was_full)
		model_q.push_back(entry_in);
endfunction

`endif

// File: sim/tb_dual_issue.sv
`timescale 1ns/1ps

module tb_dual_issue;

	localparam int QUEUE_DEPTH = 8;
	localparam int N_SINGLE    = 8;
	localparam int N_BATCH     = 300;
	localparam int BATCH_LEN   = 6;
	localparam int N_DIRECTED  = 7;
	// three apb transfers per entry, three cycles each
	localparam int PUSH_CYCLES = 9;
	localparam int RUN_CYCLES  = 16 + N_SINGLE * (PUSH_CYCLES + 2) +
		N_BATCH * (BATCH_LEN * (PUSH_CYCLES + 1) + 4) + N_DIRECTED * (2 * PUSH_CYCLES + 8) +
		(QUEUE_DEPTH + 1) * PUSH_CYCLES + QUEUE_DEPTH + 30;
	localparam int TIMEOUT_CYCLES = 2 * RUN_CYCLES;

	logic                       clk;
	logic                       arst_n;
	logic                       ena;
	logic                       access_full;
	int                         cycle_cnt;
	bus_pkg::apb_req_t          apb_req;
	bus_pkg::apb_rsp_t          apb_rsp;
	cpu_types_pkg::issue_t      issue;
	cpu_types_pkg::inst_entry_t pending_entry;

	`include "issue_model.svh"

	dual_issue_top #(.QUEUE_DEPTH(QUEUE_DEPTH)) dut_i (
		.clk     (clk),
		.arst_n  (arst_n),
		.ena     (ena),
		.apb_req (apb_req),
		.apb_rsp (apb_rsp),
		.issue   (issue)
	);

	always #10 clk = ~clk;

	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= TIMEOUT_CYCLES) begin
			$display("timeout: test did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("SIMULATION FAILED");
			$fatal(1, "run stopped by timeout");
		end
	end

	task automatic check_value(input string name, input logic [79:0] got,
			input logic [79:0] exp);
		if (got !== exp) begin
			$display("Mismatch at %0t: %s got %0h expected %0h", $time, name, got, exp);
			$display("SIMULATION FAILED");
			$fatal(1, "stopped at first error");
		end
	endtask

	// model follows each edge, inputs are still the values seen at the edge
	always @(posedge clk) begin
		#1;
		if (arst_n) begin
			apply_edge(ena, apb_req.psel && apb_req.penable && apb_req.pwrite &&
				apb_req.paddr == bus_pkg::REG_INST_PC, pending_entry);
			check_value("issue.valid_a", 80'(issue.valid_a), 80'(exp_valid_a));
			check_value("issue.valid_b", 80'(issue.valid_b), 80'(exp_valid_b));
			if (exp_valid_a)
				check_value("issue.entry_a", 80'(issue.entry_a), 80'(exp_entry_a));
			if (exp_valid_b)
				check_value("issue.entry_b", 80'(issue.entry_b), 80'(exp_entry_b));
		end
	end

	task automatic apb_xfer(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
			output logic [31:0] rdata, output logic err);
		@(posedge clk);
		#2;
		apb_req = '{psel: 1'b1, penable: 1'b0, pwrite: wr, paddr: addr, pwdata: wdata};
		@(posedge clk);
		#2;
		apb_req.penable = 1'b1;
		#10;
		check_value("pready", 80'(apb_rsp.pready), 80'(1'b1));
		rdata = apb_rsp.prdata;
		err = apb_rsp.pslverr;
		access_full = model_q.size() == QUEUE_DEPTH;
		@(posedge clk);
		#2;
		apb_req = '0;
	endtask

	task automatic push_inst(input cpu_types_pkg::inst_entry_t e, output logic err);
		logic [31:0] rd;
		apb_xfer(1'b1, bus_pkg::REG_INST_LO, {6'd0, e.delayslot, e.reg_we, e.reg_waddr,
			e.reg_addr2, e.reg_addr1, e.fpu_op, e.op}, rd, err);
		check_value("pslverr", 80'(err), 80'(1'b0));
		apb_xfer(1'b1, bus_pkg::REG_INST_HI, {16'd0, e.fpu_we, e.fpu_waddr, e.fpu_raddr2,
			e.fpu_raddr1}, rd, err);
		check_value("pslverr", 80'(err), 80'(1'b0));
		pending_entry = e;
		apb_xfer(1'b1, bus_pkg::REG_INST_PC, e.pc, rd, err);
		check_value("pslverr", 80'(err), 80'(access_full));
	endtask

	function automatic cpu_types_pkg::inst_entry_t random_inst();
		cpu_types_pkg::inst_entry_t e;
		logic [31:0] pc_bits;
		e = '0;
		e.op = cpu_types_pkg::oper_t'(6'($urandom_range(0, 24)));
		e.fpu_op = cpu_types_pkg::fpu_oper_t'(3'($urandom_range(0, 3)));
		// few register numbers so dependences show up often
		e.reg_addr1 = 5'($urandom_range(0, 3));
		e.reg_addr2 = 5'($urandom_range(0, 3));
		e.reg_waddr = 5'($urandom_range(0, 3));
		e.reg_we = 1'($urandom_range(0, 1));
		e.fpu_raddr1 = 5'($urandom_range(0, 3));
		e.fpu_raddr2 = 5'($urandom_range(0, 3));
		e.fpu_waddr = 5'($urandom_range(0, 3));
		e.fpu_we = 1'($urandom_range(0, 1));
		e.delayslot = $urandom_range(0, 7) == 0;
		pc_bits = $urandom;
		e.pc = ($urandom_range(0, 7) == 0) ? {pc_bits[31:12], 12'h000} : {pc_bits[31:2], 2'b00};
		return e;
	endfunction

	function automatic cpu_types_pkg::inst_entry_t plain_inst(input logic [31:0] pc);
		cpu_types_pkg::inst_entry_t e;
		e = '0;
		e.op = cpu_types_pkg::OP_ADD;
		e.reg_addr1 = 5'd1;
		e.reg_addr2 = 5'd2;
		e.reg_waddr = 5'd5;
		e.reg_we = 1'b1;
		e.pc = pc;
		return e;
	endfunction

	task automatic start_issue();
		@(posedge clk);
		#2;
		ena = 1'b1;
		@(negedge clk);
	endtask

	task automatic drain_queue();
		while (model_q.size() != 0)
			@(negedge clk);
		@(posedge clk);
		#2;
		ena = 1'b0;
	endtask

	task automatic run_pair(input string rule, input cpu_types_pkg::inst_entry_t a,
			input cpu_types_pkg::inst_entry_t b, input logic pair);
		logic err;
		push_inst(a, err);
		push_inst(b, err);
		check_value(rule, 80'(may_pair(a, b)), 80'(pair));
		start_issue();
		while (!issue.valid_a)
			@(negedge clk);
		check_value("issue.valid_b", 80'(issue.valid_b), 80'(pair));
		drain_queue();
	endtask

	initial begin
		cpu_types_pkg::inst_entry_t e;
		cpu_types_pkg::inst_entry_t a;
		cpu_types_pkg::inst_entry_t b;
		logic [31:0] rd;
		logic err;
		void'($urandom(32'hc2d5_c909));
		clk = 1'b0;
		arst_n = 1'b0;
		ena = 1'b0;
		apb_req = '0;
		pending_entry = '0;
		access_full = 1'b0;
		cycle_cnt = 0;
		repeat (16) @(posedge clk);
		#2;
		arst_n = 1'b1;
		ena = 1'b1;
		for (int i = 0; i < N_SINGLE; i++) begin
			e = random_inst();
			push_inst(e, err);
			@(posedge clk);
			#5;
			check_value("issue.valid_a", 80'(issue.valid_a), 80'(1'b1));
			check_value("issue.entry_a", 80'(issue.entry_a), 80'(e));
			check_value("issue.valid_b", 80'(issue.valid_b), 80'(1'b0));
		end
		drain_queue();
		for (int n = 0; n < N_BATCH; n++) begin
			for (int i = 0; i < BATCH_LEN; i++)
				push_inst(random_inst(), err);
			start_issue();
			drain_queue();
		end
		a = plain_inst(32'h0000_1004);
		b = plain_inst(32'h0000_1008);
		run_pair("pair_none", a, b, 1'b1);
		a.op = cpu_types_pkg::OP_SSNOP;
		run_pair("pair_ssnop", a, b, 1'b0);
		a.op = cpu_types_pkg::OP_BEQ;
		run_pair("pair_branch_a", a, b, 1'b0);
		a.op = cpu_types_pkg::OP_LW;
		a.reg_waddr = b.reg_addr1;
		run_pair("pair_load_use", a, b, 1'b0);
		// r0 is never a real dependence
		a.op = cpu_types_pkg::OP_MUL;
		a.reg_waddr = 5'd0;
		b.reg_addr1 = 5'd0;
		run_pair("pair_mul_r0", a, b, 1'b1);
		a = plain_inst(32'h0000_1ffc);
		b = plain_inst(32'h0000_2000);
		run_pair("pair_page", a, b, 1'b0);
		b.pc = 32'h0000_2004;
		a.fpu_op = cpu_types_pkg::FPU_OP_ADD;
		a.fpu_we = 1'b1;
		a.fpu_waddr = 5'd4;
		b.fpu_op = cpu_types_pkg::FPU_OP_ADD;
		b.fpu_raddr1 = 5'd4;
		run_pair("pair_fpu_dep", a, b, 1'b0);
		for (int i = 0; i < QUEUE_DEPTH; i++)
			push_inst(random_inst(), err);
		push_inst(random_inst(), err);
		check_value("pslverr", 80'(err), 80'(1'b1));
		apb_xfer(1'b0, bus_pkg::REG_LEVEL, 32'd0, rd, err);
		check_value("level", 80'(rd), 80'(QUEUE_DEPTH));
		check_value("issue.valid_a", 80'(issue.valid_a), 80'(1'b0));
		start_issue();
		drain_queue();
		apb_xfer(1'b0, bus_pkg::REG_DUAL_CNT, 32'd0, rd, err);
		check_value("dual_cnt", 80'(rd), 80'(model_dual_cnt));
		check_value("pslverr", 80'(err), 80'(1'b0));
		apb_xfer(1'b0, bus_pkg::REG_LEVEL, 32'd0, rd, err);
		check_value("level", 80'(rd), 80'(model_q.size()));
		apb_xfer(1'b0, 8'h20, 32'd0, rd, err);
		check_value("pslverr", 80'(err), 80'(1'b1));
		check_value("prdata", 80'(rd), 80'(0));
		$display("SIMULATION PASSED");
		$finish;
	end

endmodule

// File: flist.f
+incdir+sim
source/cpu_types_pkg.sv
source/bus_pkg.sv
source/superscalar_ctrl.sv
source/inst_queue.sv
source/apb_issue_regs.sv
source/dual_issue_top.sv
sim/tb_dual_issue.sv

// File: run.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log &&
verilator --binary --timing --assert -f flist.f --top-module tb_dual_issue -o tb_dual_issue &&
{ ./obj_dir/tb_dual_issue > sim.log 2>&1 || true; } &&
grep -qx "SIMULATION PASSED" sim.log && echo "run ok, see sim.log" ||
{ echo "run failed, see sim.log"; exit 1; }
